// File: rtl/rv_pkg.sv
// rv32i slice package: opcodes, function codes, instruction formats, issue/decode/result records
package rv_pkg;

    typedef logic [31:0] xlen_t;     // data or address word
    typedef logic [4:0]  reg_addr_t; // architectural register index

    // base opcodes kept by the slice
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101; // srl / sra
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_BLT     = 3'b100;
    localparam logic [2:0] F3_BGE     = 3'b101;
    localparam logic [2:0] F3_BLTU    = 3'b110;
    localparam logic [2:0] F3_BGEU    = 3'b111;

    localparam logic [6:0] F7_ALT     = 7'b0100000; // sub / sra

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, six views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        xlen_t  pc;
        instr_u instr;
    } issue_t;

    typedef struct packed {
        xlen_t      pc;
        xlen_t      op_a;      // alu operands
        xlen_t      op_b;
        xlen_t      cmp_a;     // branch compare operands
        xlen_t      cmp_b;
        xlen_t      jump_base; // pc or rs1
        xlen_t      imm;       // target offset
        alu_op_e    alu_op;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic       we;
        logic       is_branch;
        logic       is_jump;
        logic       illegal;
    } dec_op_t;

    typedef struct packed {
        xlen_t     pc;
        reg_addr_t rd;
        logic      we;
        xlen_t     wdata;
        logic      taken;
        xlen_t     next_pc;
        logic      illegal;
    } result_t;

endpackage

// File: rtl/rv_regfile.sv
// architectural register file: x0 hardwired to zero, two async read ports, one write port
`timescale 1ns/10ps
module rv_regfile #(
    parameter int REG_COUNT = 32
) (
    input  logic              clk,
    input  logic              reset_i,
    input  rv_pkg::reg_addr_t raddr_a_i,
    input  rv_pkg::reg_addr_t raddr_b_i,
    output rv_pkg::xlen_t     rdata_a_o,
    output rv_pkg::xlen_t     rdata_b_o,
    input  logic              we_i,
    input  rv_pkg::reg_addr_t waddr_i,
    input  rv_pkg::xlen_t     wdata_i
);
    import rv_pkg::*;

    xlen_t regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0 && int'(waddr_i) < REG_COUNT) begin
            regs[waddr_i] <= wdata_i; // x0 and out-of-range writes dropped
        end
    end

    // out-of-range index reads zero, decode flags it illegal anyway
    assign rdata_a_o = (raddr_a_i == '0 || int'(raddr_a_i) >= REG_COUNT) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0 || int'(raddr_b_i) >= REG_COUNT) ? '0 : regs[raddr_b_i];

endmodule

// File: rtl/rv_decode.sv
// decode stage: format decode, immediates, operand read with forwarding, decoded-op register
`timescale 1ns/10ps
module rv_decode #(
    parameter int REG_COUNT = 32
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  rv_pkg::issue_t    in_i,
    output rv_pkg::reg_addr_t raddr_a_o,
    output rv_pkg::reg_addr_t raddr_b_o,
    input  rv_pkg::xlen_t     rdata_a_i,
    input  rv_pkg::xlen_t     rdata_b_i,
    input  rv_pkg::result_t   fwd_i,
    input  logic              advance_i,
    output logic              op_valid_o,
    output rv_pkg::dec_op_t   op_o
);
    import rv_pkg::*;

    instr_u    ins;
    reg_addr_t rs1, rs2, rd;
    xlen_t     imm_i, imm_b, imm_u, imm_j;
    xlen_t     rs1_val, rs2_val;
    logic      legal, use_rs1, use_rs2, use_rd, bad_reg;
    dec_op_t   dec_d, dec_q;
    logic      valid_q;

    function automatic alu_op_e alu_of(logic [2:0] f3, logic alt);
        alu_op_e op;
        case (f3)
            F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SR:      op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            F3_AND:     op = ALU_AND;
            default:    op = ALU_PASS_B;
        endcase
        return op;
    endfunction

    assign ins = in_i.instr;
    assign rs1 = ins.r_fmt.rs1;
    assign rs2 = ins.r_fmt.rs2;
    assign rd  = ins.r_fmt.rd;

    assign imm_i = {{20{ins.i_fmt.imm_11_0[11]}}, ins.i_fmt.imm_11_0};
    assign imm_b = {{19{ins.b_fmt.imm_12}}, ins.b_fmt.imm_12, ins.b_fmt.imm_11,
                    ins.b_fmt.imm_10_5, ins.b_fmt.imm_4_1, 1'b0};
    assign imm_u = {ins.u_fmt.imm_31_12, 12'b0};
    assign imm_j = {{11{ins.j_fmt.imm_20}}, ins.j_fmt.imm_20, ins.j_fmt.imm_19_12,
                    ins.j_fmt.imm_11, ins.j_fmt.imm_10_1, 1'b0};

    assign raddr_a_o = rs1;
    assign raddr_b_o = rs2;

    // bypass from the op now in the decoded-op register
    assign rs1_val = (fwd_i.we && fwd_i.rd == rs1 && rs1 != '0) ? fwd_i.wdata : rdata_a_i;
    assign rs2_val = (fwd_i.we && fwd_i.rd == rs2 && rs2 != '0) ? fwd_i.wdata : rdata_b_i;

    always_comb begin
        dec_d        = '0;
        dec_d.pc     = in_i.pc;
        dec_d.funct3 = ins.r_fmt.funct3;
        dec_d.rd     = rd;
        dec_d.alu_op = ALU_PASS_B; // op_b stays zero, so wdata is zero
        dec_d.cmp_a  = rs1_val;
        dec_d.cmp_b  = rs2_val;
        legal        = 1'b0;
        use_rs1      = 1'b0;
        use_rs2      = 1'b0;
        use_rd       = 1'b0;
        case (ins.r_fmt.opcode)
            OPC_OP_IMM: begin
                use_rs1 = 1'b1;
                use_rd  = 1'b1;
                dec_d.op_a = rs1_val;
                dec_d.op_b = imm_i;        // shifts use the low five bits
                if (ins.i_fmt.funct3 == F3_SLL) begin
                    legal = ins.r_fmt.funct7 == 7'b0;
                end else if (ins.i_fmt.funct3 == F3_SR) begin
                    legal = ins.r_fmt.funct7 == 7'b0 || ins.r_fmt.funct7 == F7_ALT;
                end else begin
                    legal = 1'b1;
                end
                dec_d.alu_op = alu_of(ins.i_fmt.funct3,
                                      ins.i_fmt.funct3 == F3_SR && ins.r_fmt.funct7 == F7_ALT);
            end
            OPC_OP: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                use_rd  = 1'b1;
                dec_d.op_a = rs1_val;
                dec_d.op_b = rs2_val;
                legal = ins.r_fmt.funct7 == 7'b0 ||
                        (ins.r_fmt.funct7 == F7_ALT &&
                         (ins.r_fmt.funct3 == F3_ADD_SUB || ins.r_fmt.funct3 == F3_SR));
                dec_d.alu_op = alu_of(ins.r_fmt.funct3, ins.r_fmt.funct7 == F7_ALT);
            end
            OPC_LUI: begin
                use_rd = 1'b1;
                legal  = 1'b1;
                dec_d.op_a   = imm_u;
                dec_d.alu_op = ALU_ADD;     // op_b is zero
            end
            OPC_AUIPC: begin
                use_rd = 1'b1;
                legal  = 1'b1;
                dec_d.op_a   = in_i.pc;
                dec_d.op_b   = imm_u;
                dec_d.alu_op = ALU_ADD;
            end
            OPC_BRANCH: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                case (ins.b_fmt.funct3)
                    F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU: legal = 1'b1;
                    default: legal = 1'b0;
                endcase
                dec_d.is_branch = 1'b1;
                dec_d.jump_base = in_i.pc;
                dec_d.imm       = imm_b;
            end
            OPC_JAL, OPC_JALR: begin
                use_rd = 1'b1;
                dec_d.op_a    = in_i.pc;    // link value pc + 4
                dec_d.op_b    = 32'd4;
                dec_d.alu_op  = ALU_ADD;
                dec_d.is_jump = 1'b1;
                if (ins.r_fmt.opcode == OPC_JAL) begin
                    legal = 1'b1;
                    dec_d.jump_base = in_i.pc;
                    dec_d.imm       = imm_j;
                end else begin
                    use_rs1 = 1'b1;
                    legal   = ins.i_fmt.funct3 == 3'b000;
                    dec_d.jump_base = rs1_val;
                    dec_d.imm       = imm_i;
                end
            end
            default: legal = 1'b0;
        endcase
        bad_reg = (use_rs1 && int'(rs1) >= REG_COUNT) ||
                  (use_rs2 && int'(rs2) >= REG_COUNT) ||
                  (use_rd && int'(rd) >= REG_COUNT);
        dec_d.illegal = !legal || bad_reg;
        if (dec_d.illegal) begin
            dec_d.is_branch = 1'b0;      // illegal op falls through to pc + 4
            dec_d.is_jump   = 1'b0;
        end
        dec_d.we = use_rd && !dec_d.illegal;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (advance_i) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i && in_valid_i) begin
            dec_q <= dec_d;
        end
    end

    assign in_ready_o = advance_i; // accept whenever the op ahead moves on
    assign op_valid_o = valid_q;
    assign op_o       = dec_q;

endmodule

// File: rtl/rv_execute.sv
// execute stage: alu, branch comparator and target adder producing the result record
`timescale 1ns/10ps
module rv_execute (
    input  logic            op_valid_i,
    input  rv_pkg::dec_op_t op_i,
    output rv_pkg::result_t result_o
);
    import rv_pkg::*;

    xlen_t     alu_res;
    xlen_t     target;
    xlen_t     seq_pc;
    logic      cond;
    logic      taken;
    logic [4:0] shamt;

    assign shamt = op_i.op_b[4:0];

    always_comb begin
        case (op_i.alu_op)
            ALU_ADD:    alu_res = op_i.op_a + op_i.op_b;
            ALU_SUB:    alu_res = op_i.op_a - op_i.op_b;
            ALU_SLL:    alu_res = op_i.op_a << shamt;
            ALU_SLT:    alu_res = {31'b0, $signed(op_i.op_a) < $signed(op_i.op_b)};
            ALU_SLTU:   alu_res = {31'b0, op_i.op_a < op_i.op_b};
            ALU_XOR:    alu_res = op_i.op_a ^ op_i.op_b;
            ALU_SRL:    alu_res = op_i.op_a >> shamt;
            ALU_SRA:    alu_res = $signed(op_i.op_a) >>> shamt;
            ALU_OR:     alu_res = op_i.op_a | op_i.op_b;
            ALU_AND:    alu_res = op_i.op_a & op_i.op_b;
            default:    alu_res = op_i.op_b; // pass b
        endcase
    end

    always_comb begin
        case (op_i.funct3)
            F3_BEQ:  cond = op_i.cmp_a == op_i.cmp_b;
            F3_BNE:  cond = op_i.cmp_a != op_i.cmp_b;
            F3_BLT:  cond = $signed(op_i.cmp_a) < $signed(op_i.cmp_b);
            F3_BGE:  cond = $signed(op_i.cmp_a) >= $signed(op_i.cmp_b);
            F3_BLTU: cond = op_i.cmp_a < op_i.cmp_b;
            F3_BGEU: cond = op_i.cmp_a >= op_i.cmp_b;
            default: cond = 1'b0;
        endcase
    end

    // jalr needs bit 0 cleared, jal targets are even for any aligned pc
    assign target = (op_i.jump_base + op_i.imm) & ~{31'b0, op_i.is_jump};
    assign seq_pc = op_i.pc + 32'd4;
    assign taken  = (op_i.is_branch && cond) || op_i.is_jump;

    always_comb begin
        result_o.pc      = op_i.pc;
        result_o.rd      = op_i.rd;
        result_o.we      = op_valid_i && op_i.we; // no forwarding from an empty stage
        result_o.wdata   = alu_res;
        result_o.taken   = taken;
        result_o.next_pc = taken ? target : seq_pc;
        result_o.illegal = op_i.illegal;
    end

endmodule

// File: rtl/rv_result.sv
// result stage: output register, result handshake and register file write-back
`timescale 1ns/10ps
module rv_result (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              op_valid_i,
    input  rv_pkg::result_t   result_i,
    output logic              advance_o,
    output logic              res_valid_o,
    input  logic              res_ready_i,
    output rv_pkg::result_t   res_o,
    output logic              rf_we_o,
    output rv_pkg::reg_addr_t rf_waddr_o,
    output rv_pkg::xlen_t     rf_wdata_o
);
    import rv_pkg::*;

    result_t res_q;
    logic    valid_q;
    logic    load;

    assign advance_o = !valid_q || res_ready_i; // empty or being emptied
    assign load      = advance_o && op_valid_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (advance_o) begin
            valid_q <= op_valid_i;   // drops when taken with nothing behind
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            res_q <= result_i;
        end
    end

    // write-back lands on the same edge as the output load
    assign rf_we_o    = load && result_i.we;
    assign rf_waddr_o = result_i.rd;
    assign rf_wdata_o = result_i.wdata;

    assign res_valid_o = valid_q;
    assign res_o       = res_q;

endmodule

// File: rtl/rv_slice_top.sv
// rv32i execution slice top: decode, register file, execute and result stages
`timescale 1ns/10ps
module rv_slice_top #(
    parameter int REG_COUNT = 32   // 16 for rv32e
) (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            in_valid_i,
    output logic            in_ready_o,
    input  rv_pkg::issue_t  in_i,
    output logic            res_valid_o,
    input  logic            res_ready_i,
    output rv_pkg::result_t res_o
);
    import rv_pkg::*;

    reg_addr_t raddr_a, raddr_b;
    xlen_t     rdata_a, rdata_b;
    logic      op_valid;
    dec_op_t   dec_op;
    result_t   exe_res;
    logic      advance;
    logic      rf_we;
    reg_addr_t rf_waddr;
    xlen_t     rf_wdata;

    rv_decode #(
        .REG_COUNT (REG_COUNT)
    ) u_decode (
        .clk        (clk),
        .reset_i    (reset_i),
        .in_valid_i (in_valid_i),
        .in_ready_o (in_ready_o),
        .in_i       (in_i),
        .raddr_a_o  (raddr_a),
        .raddr_b_o  (raddr_b),
        .rdata_a_i  (rdata_a),
        .rdata_b_i  (rdata_b),
        .fwd_i      (exe_res),
        .advance_i  (advance),
        .op_valid_o (op_valid),
        .op_o       (dec_op)
    );

    rv_regfile #(
        .REG_COUNT (REG_COUNT)
    ) u_regfile (
        .clk       (clk),
        .reset_i   (reset_i),
        .raddr_a_i (raddr_a),
        .raddr_b_i (raddr_b),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata)
    );

    rv_execute u_execute (
        .op_valid_i (op_valid),
        .op_i       (dec_op),
        .result_o   (exe_res)
    );

    rv_result u_result (
        .clk         (clk),
        .reset_i     (reset_i),
        .op_valid_i  (op_valid),
        .result_i    (exe_res),
        .advance_o   (advance),
        .res_valid_o (res_valid_o),
        .res_ready_i (res_ready_i),
        .res_o       (res_o),
        .rf_we_o     (rf_we),
        .rf_waddr_o  (rf_waddr),
        .rf_wdata_o  (rf_wdata)
    );

endmodule

// File: tb/rv_slice_props.sv
// bound assertions: result handshake stability, stall back-pressure and reset state
`timescale 1ns/10ps
module rv_slice_props (
    input logic            clk,
    input logic            reset_i,
    input logic            in_ready_i,
    input logic            res_valid_i,
    input logic            res_ready_i,
    input rv_pkg::result_t res_i
);

    // stalled result keeps valid and data
    property res_held_p;
        @(posedge clk) disable iff (reset_i)
            (res_valid_i && !res_ready_i) |=> (res_valid_i && $stable(res_i));
    endproperty

    property reset_empty_p;
        @(posedge clk) reset_i |=> !res_valid_i;
    endproperty

    // full output register with no taker blocks issue
    property stall_blocks_issue_p;
        @(posedge clk) disable iff (reset_i)
            (res_valid_i && !res_ready_i) |-> !in_ready_i;
    endproperty

    res_held_a:       assert property (res_held_p) else $error("res_o changed while stalled");
    reset_empty_a:    assert property (reset_empty_p) else $error("res_valid_o high after reset");
    stall_blocks_a:   assert property (stall_blocks_issue_p)
        else $error("in_ready_o high during result stall");

endmodule

// File: tb/tb_rv_slice.sv
// testbench for the rv32i slice: clock, reset, file-driven stimulus, result checks, timeout
`timescale 1ns/10ps
module tb_rv_slice;
    import rv_pkg::*;

    logic    clk;
    logic    reset_i;
    logic    in_valid_i;
    logic    in_ready_o;
    issue_t  in_i;
    logic    res_valid_o;
    logic    res_ready_i;
    result_t res_o;

    issue_t  stim_q[$];  // issue records in file order
    result_t exp_all[$]; // expected result per issue
    result_t exp_q[$];   // accepted, result still outstanding
    int      errors;
    int      checks;
    bit      timed_out;

    rv_slice_top #(
        .REG_COUNT (32)
    ) DUT (
        .clk         (clk),
        .reset_i     (reset_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_i        (in_i),
        .res_valid_o (res_valid_o),
        .res_ready_i (res_ready_i),
        .res_o       (res_o)
    );

    bind rv_slice_top rv_slice_props u_props (
        .clk         (clk),
        .reset_i     (reset_i),
        .in_ready_i  (in_ready_o),
        .res_valid_i (res_valid_o),
        .res_ready_i (res_ready_i),
        .res_i       (res_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // one issue per data line, lines starting with # are skipped
    task automatic load_testdata(output bit opened);
        int          fd;
        int          code;
        string       line;
        logic [31:0] f_pc, f_ins, f_rd, f_we, f_val, f_tk, f_npc, f_ill;
        issue_t      iss;
        result_t     want;
        fd = $fopen("tb/rv_testdata.txt", "r");
        opened = fd != 0;
        if (opened) begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line.getc(0) != "#") begin
                    code = $sscanf(line, "%h %h %h %h %h %h %h %h",
                                   f_pc, f_ins, f_rd, f_we, f_val, f_tk, f_npc, f_ill);
                    if (code == 8) begin
                        iss.pc        = f_pc;
                        iss.instr     = f_ins;
                        want.pc       = f_pc;
                        want.rd       = f_rd[4:0];
                        want.we       = f_we[0];
                        want.wdata    = f_val;
                        want.taken    = f_tk[0];
                        want.next_pc  = f_npc;
                        want.illegal  = f_ill[0];
                        stim_q.push_back(iss);
                        exp_all.push_back(want);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic compare_result(input result_t want, input result_t act, input int idx);
        checks++;
        if (act.pc !== want.pc) begin
            errors++;
            $display("[ERROR] result %0d res_o.pc: expected %h, got %h", idx, want.pc, act.pc);
        end
        if (act.we !== want.we) begin
            errors++;
            $display("[ERROR] result %0d res_o.we: expected %h, got %h", idx, want.we, act.we);
        end
        if (want.we && act.rd !== want.rd) begin // rd and wdata only matter when written
            errors++;
            $display("[ERROR] result %0d res_o.rd: expected %h, got %h", idx, want.rd, act.rd);
        end
        if (want.we && act.wdata !== want.wdata) begin
            errors++;
            $display("[ERROR] result %0d res_o.wdata: expected %h, got %h",
                     idx, want.wdata, act.wdata);
        end
        if (act.taken !== want.taken) begin
            errors++;
            $display("[ERROR] result %0d res_o.taken: expected %h, got %h",
                     idx, want.taken, act.taken);
        end
        if (act.next_pc !== want.next_pc) begin
            errors++;
            $display("[ERROR] result %0d res_o.next_pc: expected %h, got %h",
                     idx, want.next_pc, act.next_pc);
        end
        if (act.illegal !== want.illegal) begin
            errors++;
            $display("[ERROR] result %0d res_o.illegal: expected %h, got %h",
                     idx, want.illegal, act.illegal);
        end
    endtask

    // drive at +1 ns after the edge, sample at the falling edge
    task automatic run_tests(input int limit);
        int      sent;
        int      got;
        int      cycles;
        bit      accepted;
        result_t want;
        sent     = 0;
        got      = 0;
        cycles   = 0;
        accepted = 1'b0;
        while (got < stim_q.size() && cycles < limit) begin
            @(posedge clk);
            #1;
            cycles++;
            if (accepted) begin
                in_valid_i = 1'b0;
                accepted   = 1'b0;
            end
            if (!in_valid_i && sent < stim_q.size() && ($urandom % 4) != 0) begin
                in_i       = stim_q[sent]; // held until accepted
                in_valid_i = 1'b1;
            end
            res_ready_i = ($urandom % 4) != 0; // random stalls
            @(negedge clk);
            if (in_valid_i && in_ready_o) begin
                exp_q.push_back(exp_all[sent]);
                sent++;
                accepted = 1'b1;
            end
            if (res_valid_o && res_ready_i) begin
                got++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("a result arrived with no instruction outstanding");
                end else begin
                    want = exp_q.pop_front();
                    compare_result(want, res_o, got);
                end
            end
        end
        if (got < stim_q.size()) begin
            timed_out = 1'b1;
            $display("timeout: only %0d of %0d results arrived within %0d cycles",
                     got, stim_q.size(), limit);
        end else begin
            // nothing more may come out once every issue has its result
            repeat (4) begin
                @(posedge clk);
                #1;
                in_valid_i  = 1'b0;
                res_ready_i = 1'b1;
                @(negedge clk);
                if (res_valid_o) begin
                    errors++;
                    $display("an extra result appeared after the last instruction");
                end
            end
        end
    endtask

    initial begin
        bit opened;
        reset_i     = 1'b1;
        in_valid_i  = 1'b0;
        in_i        = '0;
        res_ready_i = 1'b0;
        errors      = 0;
        checks      = 0;
        timed_out   = 1'b0;
        void'($urandom(32'ha4ad));
        load_testdata(opened);
        repeat (10) @(posedge clk);
        #1;
        reset_i = 1'b0;
        if (!opened) begin
            errors++;
            $display("could not open the test data file tb/rv_testdata.txt");
        end else if (stim_q.size() == 0) begin
            errors++;
            $display("the test data file holds no instructions");
        end else begin
            run_tests(40 * stim_q.size() + 100);
        end
        $display("results checked: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tb/rv_testdata.txt
# pc instr rd we value taken next_pc illegal, all hex, rd and value only checked when we is 1
# registers start at zero, pc runs in steps of 4 whatever the branch outcome
00000100 00500093 01 1 00000005 0 00000104 0
00000104 ffd00113 02 1 fffffffd 0 00000108 0
00000108 002081b3 03 1 00000002 0 0000010c 0
0000010c 40208233 04 1 00000008 0 00000110 0
00000110 001122b3 05 1 00000001 0 00000114 0
00000114 00113333 06 1 00000000 0 00000118 0
00000118 401153b3 07 1 ffffffff 0 0000011c 0
0000011c 00115433 08 1 07ffffff 0 00000120 0
00000120 02300513 0a 1 00000023 0 00000124 0
00000124 00a094b3 09 1 00000028 0 00000128 0
00000128 0f014593 0b 1 ffffff0d 0 0000012c 0
0000012c 7000e613 0c 1 00000705 0 00000130 0
00000130 ff017693 0d 1 fffffff0 0 00000134 0
00000134 4046d813 10 1 ffffffff 0 00000138 0
00000138 0046d893 11 1 0fffffff 0 0000013c 0
0000013c ffe12713 0e 1 00000001 0 00000140 0
00000140 fff0b793 0f 1 00000001 0 00000144 0
00000144 00708013 00 1 0000000c 0 00000148 0
00000148 00100933 12 1 00000005 0 0000014c 0
0000014c 123459b7 13 1 12345000 0 00000150 0
00000150 00001a17 14 1 00001150 0 00000154 0
00000154 01208863 00 0 00000000 1 00000164 0
00000158 01209863 00 0 00000000 0 0000015c 0
0000015c fe114ce3 00 0 00000000 1 00000154 0
00000160 fe115ce3 00 0 00000000 0 00000164 0
00000164 00116463 00 0 00000000 0 00000168 0
00000168 00117463 00 0 00000000 1 00000170 0
0000016c 02000aef 15 1 00000170 1 0000018c 0
00000170 01008b67 16 1 00000174 1 00000014 0
00000174 001b0be7 17 1 00000178 1 00000174 0
00000178 0000028b 00 0 00000000 0 0000017c 1
0000017c 401091b3 00 0 00000000 0 00000180 1
00000180 40009213 00 0 00000000 0 00000184 1
00000184 0120a863 00 0 00000000 0 00000188 1
00000188 00418c33 18 1 0000000a 0 0000018c 0
0000018c 00028c93 19 1 00000001 0 00000190 0

// File: sources.f
rtl/rv_pkg.sv
rtl/rv_regfile.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_result.sv
rtl/rv_slice_top.sv
tb/rv_slice_props.sv
tb/tb_rv_slice.sv

// File: Makefile
sim:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module tb_rv_slice -f sources.f -o sim_tb
	-./obj_dir/sim_tb > sim.log 2>&1
	cat sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
